// File: flist.f
fetch_pkg.sv
fetch_if.sv
fetch_requester.sv
next_pc_predictor.sv
redirect_ctrl.sv
inst_buffer.sv
fetch_unit.sv
tb_fetch_unit.sv

// File: Bender.yml
package:
  name: fetch_unit

sources:
  - fetch_pkg.sv
  - fetch_if.sv
  - fetch_requester.sv
  - next_pc_predictor.sv
  - redirect_ctrl.sv
  - inst_buffer.sv
  - fetch_unit.sv
  - target: test
    files:
      - tb_fetch_unit.sv

// File: tb_fetch_unit.sv
`timescale 1ns/1ps

module tb_fetch_unit;

    logic        clk = 1'b0;
    logic        rst;
    logic        mem_req;
    logic [31:0] mem_addr;
    logic        mem_valid;
    logic [31:0] mem_data;
    logic        branch_taken;
    logic [31:0] branch_pc;
    logic [31:0] branch_target;
    logic        jalr_valid;
    logic [31:0] jalr_target;
    logic        iq_full;
    logic        lsb_full;
    logic        inst_valid;
    logic [31:0] inst;
    logic [31:0] inst_pc;
    logic        flush;

    logic [31:0] mem [logic [31:0]];
    logic [31:0] req_addr;
    int          lat_cnt;
    logic [31:0] exp_pc;            // Reference pc stream
    logic        held;
    logic        bp_q;
    logic [31:0] redir_target;
    logic [31:0] watch_pc;
    logic        watch_hit;
    int          n_req;
    int          n_valid;
    int          n_flush;
    int          errors;
    int          n_fail;

    fetch_unit #(
        .RESET_PC  (32'h0000_1000),
        .BUF_DEPTH (4)
    ) DUT (
        .clk           (clk),
        .rst           (rst),
        .mem_req       (mem_req),
        .mem_addr      (mem_addr),
        .mem_valid     (mem_valid),
        .mem_data      (mem_data),
        .branch_taken  (branch_taken),
        .branch_pc     (branch_pc),
        .branch_target (branch_target),
        .jalr_valid    (jalr_valid),
        .jalr_target   (jalr_target),
        .iq_full       (iq_full),
        .lsb_full      (lsb_full),
        .inst_valid    (inst_valid),
        .inst          (inst),
        .inst_pc       (inst_pc),
        .flush         (flush)
    );

    always #10 clk = ~clk;

    // Unwritten words are ALU ops whose upper bits follow the address
    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        if (mem.exists(addr)) begin
            return mem[addr];
        end
        return {addr[24:0] ^ addr[31:7], 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_jal(input logic [31:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd0, 7'b1101111};
    endfunction

    function automatic logic [31:0] enc_branch(input logic [31:0] off);
        return {off[12], off[10:5], 10'd0, 3'b000, off[4:1], off[11], 7'b1100011};
    endfunction

    task automatic check(input bit ok, input string msg);
        assert (ok) else begin
            $display("ERR %0t: %s", $time, msg);
            errors++;
        end
    endtask

    // Memory with 1 to 4 cycles of latency, stale reads answered too
    always @(posedge clk) begin
        mem_valid <= 1'b0;
        if (rst) begin
            lat_cnt = 0;
        end else begin
            if (mem_req) begin
                req_addr = mem_addr;
                lat_cnt  = $urandom_range(4, 1);
            end
            if (lat_cnt != 0) begin
                lat_cnt = lat_cnt - 1;
                if (lat_cnt == 0) begin
                    mem_valid <= 1'b1;
                    mem_data  <= mem_word(req_addr);
                end
            end
        end
    end

    // Compares every delivered instruction with the reference stream
    always @(posedge clk) begin
        logic [31:0] w;
        if (!rst) begin
            n_req   += mem_req;
            n_flush += flush;
            if (inst_valid) begin
                n_valid++;
                w = mem_word(exp_pc);
                check(!held, "instruction delivered while fetch waits on JALR");
                check(!bp_q, "instruction delivered under back-pressure");
                check(inst_pc == exp_pc, $sformatf("inst_pc %h, expected %h", inst_pc, exp_pc));
                check(inst == w, $sformatf("inst %h at %h, expected %h", inst, exp_pc, w));
                if (inst_pc == watch_pc) begin
                    watch_hit = 1'b1;
                end
                if (w[6:0] == 7'b1101111) begin
                    exp_pc = exp_pc + fetch_pkg::j_imm(w);
                end else if (w[6:0] == 7'b1100111) begin
                    held = 1'b1;
                end else begin
                    exp_pc = exp_pc + 32'd4;           // Branches predicted not taken
                end
            end
            if (flush) begin
                exp_pc = redir_target;
                held   = 1'b0;
            end
            bp_q = iq_full || lsb_full;
        end
    end

    task automatic wait_pc(input logic [31:0] pc);
        int n;
        watch_pc  = pc;
        watch_hit = 1'b0;
        n = 0;
        while (!watch_hit && n < 300) begin
            @(posedge clk);
            n++;
        end
        if (!watch_hit) begin
            $display("Timeout: pc %h was never delivered", pc);
            errors++;
        end
    endtask

    task automatic strobe_branch(input logic [31:0] pc, input logic [31:0] target);
        @(posedge clk);
        redir_target = target;
        branch_taken  <= 1'b1;
        branch_pc     <= pc;
        branch_target <= target;
        @(posedge clk);
        branch_taken <= 1'b0;
    endtask

    // Mispredicted branch from outside the program, lands on addr
    task automatic jump_to(input logic [31:0] addr);
        strobe_branch(32'h0000_0f00, addr);
        wait_pc(addr);
    endtask

    task automatic finish_test(input string name, input int e0);
        if (errors == e0) begin
            $display("Test %s: OK", name);
        end else begin
            $display("Test %s: FAILED with %0d errors", name, errors - e0);
            n_fail++;
        end
    endtask

    task automatic test_sequential();
        int e0;
        e0 = errors;
        wait_pc(32'h0000_101c);
        check(n_flush == 0, "flush during straight-line fetch");
        finish_test("sequential", e0);
    endtask

    task automatic test_jal();
        int e0;
        int f0;
        e0 = errors;
        mem[32'h0000_2008] = enc_jal(32'h40);
        jump_to(32'h0000_2000);
        f0 = n_flush;
        wait_pc(32'h0000_2048);
        wait_pc(32'h0000_2050);
        check(n_flush == f0, "flush after JAL");
        finish_test("jal", e0);
    endtask

    task automatic test_jalr_hold();
        int e0;
        int f0;
        int r0;
        int v0;
        e0 = errors;
        mem[32'h0000_3008] = 32'h0000_8067;    // jalr x0, 0(x1)
        jump_to(32'h0000_3000);
        wait_pc(32'h0000_3008);
        f0 = n_flush;
        r0 = n_req;
        v0 = n_valid;
        repeat (30) @(posedge clk);
        check(n_req == r0 && n_valid == v0, "fetch continued past JALR");
        exp_pc = 32'h0000_3100;
        held   = 1'b0;
        jalr_valid  <= 1'b1;
        jalr_target <= 32'h0000_3100;
        @(posedge clk);
        jalr_valid <= 1'b0;
        wait_pc(32'h0000_3108);
        check(n_flush == f0, "flush on JALR resolution");
        finish_test("jalr_hold", e0);
    endtask

    task automatic test_branch();
        int e0;
        int f0;
        e0 = errors;
        mem[32'h0000_4008] = enc_branch(32'h20);
        mem[32'h0000_4030] = enc_branch(32'h4);
        jump_to(32'h0000_4000);
        wait_pc(32'h0000_4008);
        f0 = n_flush;
        strobe_branch(32'h0000_4008, 32'h0000_4008 + fetch_pkg::b_imm(mem[32'h0000_4008]));
        wait_pc(32'h0000_4028);
        check(n_flush == f0 + 1, "mispredicted branch did not give one flush pulse");
        wait_pc(32'h0000_4030);
        strobe_branch(32'h0000_4030, 32'h0000_4030 + fetch_pkg::b_imm(mem[32'h0000_4030]));
        wait_pc(32'h0000_4040);
        check(n_flush == f0 + 1, "flush on a fall-through branch");
        finish_test("branch", e0);
    endtask

    task automatic test_back_pressure();
        int e0;
        int v0;
        int n;
        e0 = errors;
        for (int ph = 0; ph < 2; ph++) begin
            @(posedge clk);
            if (ph == 0) begin
                iq_full <= 1'b1;
            end else begin
                lsb_full <= 1'b1;
            end
            repeat ($urandom_range(20, 5)) @(posedge clk);
            iq_full  <= 1'b0;
            lsb_full <= 1'b0;
            v0 = n_valid;
            n  = 0;
            while (n_valid < v0 + 6 && n < 300) begin
                @(posedge clk);
                n++;
            end
            if (n_valid < v0 + 6) begin
                $display("Timeout: stream did not resume after back-pressure");
                errors++;
            end
        end
        finish_test("back_pressure", e0);
    endtask

    initial begin
        void'($urandom(32'h98a0c7b1));
        rst           = 1'b1;
        mem_valid     = 1'b0;
        mem_data      = '0;
        branch_taken  = 1'b0;
        branch_pc     = '0;
        branch_target = '0;
        jalr_valid    = 1'b0;
        jalr_target   = '0;
        iq_full       = 1'b0;
        lsb_full      = 1'b0;
        exp_pc        = 32'h0000_1000;
        held          = 1'b0;
        bp_q          = 1'b0;
        redir_target  = '0;
        watch_pc      = '0;
        watch_hit     = 1'b0;
        n_req         = 0;
        n_valid       = 0;
        n_flush       = 0;
        errors        = 0;
        n_fail        = 0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        test_sequential();
        test_jal();
        test_jalr_hold();
        test_branch();
        test_back_pressure();
        $display("Tests: 5, failed: %0d, errors: %0d", n_fail, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
    parameter logic [fetch_pkg::XLEN-1:0] RESET_PC  = '0,
    parameter int                         BUF_DEPTH = 4
) (
    input  logic                        clk,
    input  logic                        rst,
    output logic                        mem_req,
    output logic [fetch_pkg::XLEN-1:0]  mem_addr,
    input  logic                        mem_valid,
    input  logic [fetch_pkg::XLEN-1:0]  mem_data,
    input  logic                        branch_taken,
    input  logic [fetch_pkg::XLEN-1:0]  branch_pc,
    input  logic [fetch_pkg::XLEN-1:0]  branch_target,
    input  logic                        jalr_valid,
    input  logic [fetch_pkg::XLEN-1:0]  jalr_target,
    input  logic                        iq_full,
    input  logic                        lsb_full,
    output logic                        inst_valid,
    output logic [fetch_pkg::XLEN-1:0]  inst,
    output logic [fetch_pkg::XLEN-1:0]  inst_pc,
    output logic                        flush
);

    logic                       redirect_valid;
    logic [fetch_pkg::XLEN-1:0] redirect_pc;
    logic                       push;
    logic [fetch_pkg::XLEN-1:0] push_pc;
    logic [fetch_pkg::XLEN-1:0] push_inst;
    logic                       room;

    fetch_if fi ();

    fetch_requester #(
        .RESET_PC (RESET_PC)
    ) u_requester (
        .clk            (clk),
        .rst            (rst),
        .mem_req        (mem_req),
        .mem_addr       (mem_addr),
        .mem_valid      (mem_valid),
        .mem_data       (mem_data),
        .fi             (fi.requester),
        .room           (room),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    next_pc_predictor u_predictor (
        .clk            (clk),
        .rst            (rst),
        .fi             (fi.predictor),
        .redirect_valid (redirect_valid),
        .push           (push),
        .push_pc        (push_pc),
        .push_inst      (push_inst)
    );

    redirect_ctrl u_redirect (
        .clk            (clk),
        .rst            (rst),
        .branch_taken   (branch_taken),
        .branch_pc      (branch_pc),
        .branch_target  (branch_target),
        .jalr_valid     (jalr_valid),
        .jalr_target    (jalr_target),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .flush          (flush)
    );

    inst_buffer #(
        .BUF_DEPTH (BUF_DEPTH)
    ) u_buffer (
        .clk        (clk),
        .rst        (rst),
        .push       (push),
        .push_pc    (push_pc),
        .push_inst  (push_inst),
        .flush      (flush),
        .iq_full    (iq_full),
        .lsb_full   (lsb_full),
        .room       (room),
        .inst_valid (inst_valid),
        .inst       (inst),
        .inst_pc    (inst_pc)
    );

endmodule

// File: inst_buffer.sv
`timescale 1ns/1ps

module inst_buffer #(
    parameter int BUF_DEPTH = 4
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        push,
    input  logic [fetch_pkg::XLEN-1:0]  push_pc,
    input  logic [fetch_pkg::XLEN-1:0]  push_inst,
    input  logic                        flush,
    input  logic                        iq_full,
    input  logic                        lsb_full,
    output logic                        room,
    output logic                        inst_valid,
    output logic [fetch_pkg::XLEN-1:0]  inst,
    output logic [fetch_pkg::XLEN-1:0]  inst_pc
);

    localparam int PTR_W = $clog2(BUF_DEPTH);

    logic [fetch_pkg::XLEN-1:0] pc_mem   [BUF_DEPTH];
    logic [fetch_pkg::XLEN-1:0] inst_mem [BUF_DEPTH];
    logic [PTR_W-1:0]           wr_ptr;
    logic [PTR_W-1:0]           rd_ptr;
    logic [PTR_W:0]             count;
    logic                       pop;

    assign pop  = (count != '0) && !iq_full && !lsb_full;
    assign room = count <= (PTR_W + 1)'(BUF_DEPTH - 2);  // One slot kept for the read in flight

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            inst_valid <= 1'b0;
        end else begin
            inst_valid <= pop;
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Storage and output payload
    always_ff @(posedge clk) begin
        if (push) begin
            pc_mem[wr_ptr]   <= push_pc;
            inst_mem[wr_ptr] <= push_inst;
        end
        if (pop) begin
            inst    <= inst_mem[rd_ptr];
            inst_pc <= pc_mem[rd_ptr];
        end
    end

endmodule

// File: redirect_ctrl.sv
`timescale 1ns/1ps

module redirect_ctrl (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        branch_taken,
    input  logic [fetch_pkg::XLEN-1:0]  branch_pc,
    input  logic [fetch_pkg::XLEN-1:0]  branch_target,
    input  logic                        jalr_valid,
    input  logic [fetch_pkg::XLEN-1:0]  jalr_target,
    output logic                        redirect_valid,
    output logic [fetch_pkg::XLEN-1:0]  redirect_pc,
    output logic                        flush
);

    logic [fetch_pkg::XLEN-1:0] fall_through;
    logic                       mispredict;

    assign fall_through = branch_pc + fetch_pkg::XLEN'(fetch_pkg::INST_BYTES);

    // Fetch assumed not taken, so only a target off the fall-through path matters
    assign mispredict = branch_taken && (branch_target != fall_through);

    always_ff @(posedge clk) begin
        if (rst) begin
            redirect_valid <= 1'b0;
            flush          <= 1'b0;
        end else begin
            redirect_valid <= mispredict || jalr_valid;
            flush          <= mispredict;      // JALR held fetch, nothing to squash
        end
    end

    always_ff @(posedge clk) begin
        if (mispredict) begin
            redirect_pc <= branch_target;      // Branch wins over a same-cycle JALR
        end else if (jalr_valid) begin
            redirect_pc <= jalr_target;
        end
    end

endmodule

// File: next_pc_predictor.sv
`timescale 1ns/1ps

module next_pc_predictor (
    input  logic                        clk,
    input  logic                        rst,
    fetch_if.predictor                  fi,
    input  logic                        redirect_valid,
    output logic                        push,
    output logic [fetch_pkg::XLEN-1:0]  push_pc,
    output logic [fetch_pkg::XLEN-1:0]  push_inst
);

    fetch_pkg::opcode_e         op;
    logic [fetch_pkg::XLEN-1:0] seq_pc;

    assign op     = fetch_pkg::opcode_e'(fi.word[6:0]);
    assign seq_pc = fi.word_pc + fetch_pkg::XLEN'(fetch_pkg::INST_BYTES);

    // Branches predicted not taken, JALR address unused while fetch holds
    always_comb begin
        case (op)
            fetch_pkg::OP_JAL: begin
                fi.next_pc = fi.word_pc + fetch_pkg::j_imm(fi.word);
            end
            default: begin
                fi.next_pc = seq_pc;
            end
        endcase
    end

    // Stall until execution reports the JALR target
    always_ff @(posedge clk) begin
        if (rst) begin
            fi.next_hold <= 1'b0;
        end else if (redirect_valid) begin
            fi.next_hold <= 1'b0;
        end else if (fi.word_valid && op == fetch_pkg::OP_JALR) begin
            fi.next_hold <= 1'b1;
        end
    end

    assign push      = fi.word_valid;
    assign push_pc   = fi.word_pc;
    assign push_inst = fi.word;

endmodule

// File: fetch_requester.sv
`timescale 1ns/1ps

module fetch_requester #(
    parameter logic [fetch_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                        clk,
    input  logic                        rst,
    output logic                        mem_req,
    output logic [fetch_pkg::XLEN-1:0]  mem_addr,
    input  logic                        mem_valid,
    input  logic [fetch_pkg::XLEN-1:0]  mem_data,
    fetch_if.requester                  fi,
    input  logic                        room,
    input  logic                        redirect_valid,
    input  logic [fetch_pkg::XLEN-1:0]  redirect_pc
);

    logic [fetch_pkg::XLEN-1:0] fetch_pc;
    logic                       outstanding;
    logic                       stale;        // In-flight read belongs to an old path
    logic                       can_issue;

    // Hold off in the word_valid cycle, fetch_pc is still the old address there
    assign can_issue = !outstanding && !fi.word_valid && room && !fi.next_hold &&
                       !redirect_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_pc    <= RESET_PC;
            outstanding <= 1'b0;
            stale       <= 1'b0;
            mem_req     <= 1'b0;
            fi.word_valid <= 1'b0;
        end else begin
            mem_req <= can_issue;
            if (can_issue) begin
                outstanding <= 1'b1;
            end else if (mem_valid && outstanding) begin
                outstanding <= 1'b0;
            end

            if (mem_valid) begin
                stale <= 1'b0;
            end else if (redirect_valid && outstanding) begin
                stale <= 1'b1;                // Drop whatever comes back
            end

            fi.word_valid <= mem_valid && outstanding && !stale && !redirect_valid;

            if (redirect_valid) begin
                fetch_pc <= redirect_pc;
            end else if (fi.word_valid) begin
                fetch_pc <= fi.next_pc;
            end
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (can_issue) begin
            mem_addr <= fetch_pc;
        end
        if (mem_valid) begin
            fi.word    <= mem_data;
            fi.word_pc <= mem_addr;            // Address of the request being answered
        end
    end

endmodule

// File: fetch_if.sv
`timescale 1ns/1ps

interface fetch_if;

    logic                        word_valid;  // Fetched word present, one cycle
    logic [fetch_pkg::XLEN-1:0]  word_pc;
    logic [fetch_pkg::XLEN-1:0]  word;
    logic [fetch_pkg::XLEN-1:0]  next_pc;     // Predicted next fetch address
    logic                        next_hold;   // Waiting on a JALR target

    modport requester (
        output word_valid, word_pc, word,
        input  next_pc, next_hold
    );

    modport predictor (
        input  word_valid, word_pc, word,
        output next_pc, next_hold
    );

endinterface

// File: fetch_pkg.sv
package fetch_pkg;

    localparam int XLEN       = 32;
    localparam int INST_BYTES = 4;

    // Major opcodes the predictor cares about, anything else runs sequentially
    typedef enum logic [6:0] {
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_AUIPC  = 7'b0010111
    } opcode_e;

    // J-type immediate, bit 0 always zero
    function automatic logic [XLEN-1:0] j_imm(input logic [XLEN-1:0] w);
        logic [XLEN-1:0] imm;
        imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        return imm;
    endfunction

    // B-type immediate
    function automatic logic [XLEN-1:0] b_imm(input logic [XLEN-1:0] w);
        logic [XLEN-1:0] imm;
        imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        return imm;
    endfunction

endpackage
